/* verilog.f */
+incdir+include
logic/cpuPkg.sv
logic/regFileIf.sv
logic/controlUnit.sv
logic/aluUnit.sv
logic/registerFile.sv
logic/branchUnit.sv
logic/fetchUnit.sv
logic/dataMemory.sv
logic/cpuTop.sv
bench/cpuRefModel.sv
bench/cpuTb.sv

/* Bender.yml */
package:
  name: cpu16

sources:
  - include_dirs:
      - include
    files:
      - logic/cpuPkg.sv
      - logic/regFileIf.sv
      - logic/controlUnit.sv
      - logic/aluUnit.sv
      - logic/registerFile.sv
      - logic/branchUnit.sv
      - logic/fetchUnit.sv
      - logic/dataMemory.sv
      - logic/cpuTop.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/cpuRefModel.sv
      - bench/cpuTb.sv

/* bench/cpuTb.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cpu_defs.svh"

module cpuTb
	import cpuRefModel::*;
;

	localparam int ClkPeriod = 8;
	localparam int ResetCycles = 4;
	localparam int HaltCycles = 4;
	localparam int NumTests = 5;
	localparam int MaxProgLen = 256;
	// Every program fits the instruction memory and runs straight through
	localparam int TimeoutNs = NumTests * (MaxProgLen + ResetCycles + HaltCycles + 2) * ClkPeriod
		+ 100 * ClkPeriod;

	logic clk;
	logic rstN;
	logic [`WORD_WIDTH-1:0] imemAddr;
	logic [`WORD_WIDTH-1:0] imemData;
	logic [`WORD_WIDTH-1:0] pc;
	logic hlt;
	logic wbEn;
	logic [`REG_IDX_WIDTH-1:0] wbIdx;
	logic [`WORD_WIDTH-1:0] wbData;

	logic [15:0] imem [256];
	int errors;
	int checks;
	int haltCount;
	logic running;

	cpuTop DUT (
		.clk(clk), .rstN(rstN), .imemAddr(imemAddr), .imemData(imemData),
		.pc(pc), .hlt(hlt), .wbEn(wbEn), .wbIdx(wbIdx), .wbData(wbData)
	);

	// Instruction memory, same-cycle read
	assign imemData = imem[imemAddr[8:1]];

	initial begin
		clk = 1'b0;
		forever #(ClkPeriod / 2) clk = ~clk;
	end

	task automatic checkValue(input string name, input logic [15:0] got,
			input logic [15:0] exp);
		checks++;
		assert (got === exp)
		else begin
			errors++;
			$display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	// ==============================
	// Comparator
	// ==============================
	// Outputs settle after the rising edge, sampled mid-cycle
	always @(negedge clk) begin : compare
		stepT expStep;
		logic [15:0] expPc;
		// Trace stays quiet while reset is held
		if (!rstN)
			checkValue("wbEn", 16'(wbEn), 16'd0);
		if (running && rstN) begin
			expPc = modelPc;
			checkValue("pc", pc, expPc);
			checkValue("imemAddr", imemAddr, expPc);
			expStep = refStep(imem[expPc[8:1]]);
			checkValue("hlt", 16'(hlt), 16'(expStep.hlt));
			checkValue("wbEn", 16'(wbEn), 16'(expStep.en));
			if (expStep.en) begin
				checkValue("wbIdx", 16'(wbIdx), 16'(expStep.idx));
				checkValue("wbData", wbData, expStep.data);
			end
			if (expStep.hlt)
				haltCount++;
		end
	end

	// ==============================
	// Stimulus
	// ==============================
	initial begin
		rstN = 1'b0;
		running = 1'b0;
		errors = 0;
		checks = 0;
		haltCount = 0;
		for (int i = 0; i < 256; i++)
			imem[i] = {4'hF, 12'(i)};
		for (int t = 0; t < NumTests; t++) begin
			buildProgram(t);
			@(posedge clk);
			rstN <= 1'b0;
			// Unused words decode as HLT
			for (int i = 0; i < 256; i++)
				imem[i] <= (i < prog.size()) ? prog[i] : {4'hF, 12'(i)};
			modelReset();
			repeat (ResetCycles) @(posedge clk);
			rstN <= 1'b1;
			haltCount = 0;
			running = 1'b1;
			// Hold in halt a few cycles to watch pc and wbEn stay put
			wait (haltCount >= HaltCycles);
			running = 1'b0;
		end
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

	// Watchdog
	initial begin
		#(TimeoutNs);
		$display("Timeout: the programs did not all reach HLT in time");
		$display("Checks run: %0d, errors: %0d", checks, errors);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

/* bench/cpuRefModel.sv */
`default_nettype none

package cpuRefModel;

	// One retired instruction as seen on the trace
	typedef struct packed {
		logic en;
		logic [3:0] idx;
		logic [15:0] data;
		logic hlt;
	} stepT;

	// ==============================
	// Architectural state
	// ==============================
	logic [15:0] modelRegs [16];
	logic [15:0] modelMem [256];
	logic [15:0] modelPc;
	logic flagN;
	logic flagV;
	logic flagZ;

	// Program image and random source
	logic [15:0] prog [$];
	integer seed = 55;

	function automatic void modelReset();
		for (int i = 0; i < 16; i++)
			modelRegs[i] = '0;
		for (int i = 0; i < 256; i++)
			modelMem[i] = '0;
		modelPc = '0;
		flagN = 1'b0;
		flagV = 1'b0;
		flagZ = 1'b0;
	endfunction

	// Signed byte add clamped to -128..127
	function automatic logic [7:0] satByte(input logic [7:0] x, input logic [7:0] y);
		logic [8:0] s;
		s = {x[7], x} + {y[7], y};
		if (s[8] != s[7])
			return s[8] ? 8'h80 : 8'h7F;
		return s[7:0];
	endfunction

	// Branch condition table on stored flags
	function automatic logic condMet(input logic [2:0] c);
		case (c)
			3'd0: return !flagZ;
			3'd1: return flagZ;
			3'd2: return !flagZ && !flagN;
			3'd3: return flagN;
			3'd4: return flagZ || !flagN;
			3'd5: return flagN || flagZ;
			3'd6: return flagV;
			default: return 1'b1;
		endcase
	endfunction

	// ==============================
	// Instruction-set step
	// ==============================
	function automatic stepT refStep(input logic [15:0] instr);
		stepT s;
		logic [3:0] op;
		logic [3:0] rd;
		logic [3:0] rs;
		logic [3:0] rt;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] r;
		logic [15:0] addr;
		logic [15:0] nextPc;
		logic ovf;
		op = instr[15:12];
		rd = instr[11:8];
		rs = instr[7:4];
		rt = instr[3:0];
		a = modelRegs[rs];
		b = modelRegs[rt];
		r = '0;
		ovf = 1'b0;
		// Word offset, tests keep the base clear of saturation
		addr = a + {{11{rt[3]}}, rt, 1'b0};
		nextPc = modelPc + 16'd2;
		case (op)
			4'h0: begin
				r = a + b;
				ovf = (a[15] == b[15]) && (r[15] != a[15]);
			end
			4'h1: begin
				r = a - b;
				ovf = (a[15] != b[15]) && (r[15] != a[15]);
			end
			4'h2: r = a ^ b;
			4'h4: r = a << rt;
			4'h5: r = $signed(a) >>> rt;
			4'h6: r = (a >> rt) | (a << (5'd16 - rt));
			4'h7: r = {satByte(a[15:8], b[15:8]), satByte(a[7:0], b[7:0])};
			4'h8: r = modelMem[addr[8:1]];
			4'h9: modelMem[addr[8:1]] = modelRegs[rd];
			4'hA: r = {modelRegs[rd][15:8], instr[7:0]};
			4'hB: r = {instr[7:0], modelRegs[rd][7:0]};
			4'hC: if (condMet(instr[11:9]))
				nextPc = nextPc + {{6{instr[8]}}, instr[8:0], 1'b0};
			4'hD: if (condMet(instr[11:9]))
				nextPc = a;
			4'hE: r = modelPc + 16'd2;
			4'hF: nextPc = modelPc;
			default: ;
		endcase
		// Saturate, then N and V from ADD and SUB only
		if (op == 4'h0 || op == 4'h1) begin
			if (ovf)
				r = a[15] ? 16'h8000 : 16'h7FFF;
			flagN = r[15];
			flagV = ovf;
		end
		if (op inside {4'h0, 4'h1, 4'h2, 4'h4, 4'h5, 4'h6})
			flagZ = (r == '0);
		s.en = op inside {4'h0, 4'h1, 4'h2, 4'h4, 4'h5, 4'h6, 4'h7, 4'h8, 4'hA, 4'hB, 4'hE};
		s.idx = rd;
		s.data = r;
		s.hlt = (op == 4'hF);
		if (s.en && rd != '0)
			modelRegs[rd] = r;
		modelPc = nextPc;
		return s;
	endfunction

	// ==============================
	// Program builder
	// ==============================
	function automatic logic [15:0] randWord();
		return 16'($random(seed));
	endfunction

	function automatic void emit(input logic [15:0] w);
		prog.push_back(w);
	endfunction

	function automatic logic [15:0] enc(input logic [3:0] op, input logic [3:0] f2,
			input logic [3:0] f1, input logic [3:0] f0);
		return {op, f2, f1, f0};
	endfunction

	// LLB keeps the old high byte, LHB then keeps the new low byte
	function automatic void loadWord(input logic [3:0] rd, input logic [15:0] v);
		emit(enc(4'hA, rd, v[7:4], v[3:0]));
		emit(enc(4'hB, rd, v[15:12], v[11:8]));
	endfunction

	// One flag-setting scenario, then a branch over a marker
	function automatic void branchCase(input int sc, input logic [2:0] c);
		case (sc)
			0: emit(enc(4'h1, 4'd3, 4'd12, 4'd15));
			1: emit(enc(4'h1, 4'd3, 4'd15, 4'd12));
			2: emit(enc(4'h1, 4'd3, 4'd12, 4'd12));
			3: emit(enc(4'h0, 4'd3, 4'd6, 4'd15));
			4: begin
				emit(enc(4'h0, 4'd3, 4'd6, 4'd15));
				emit(enc(4'h2, 4'd3, 4'd12, 4'd15));
			end
			default: begin
				emit(enc(4'h1, 4'd3, 4'd15, 4'd12));
				emit(enc(4'h5, 4'd3, 4'd15, 4'd1));
			end
		endcase
		emit({4'hC, c, 9'd1});
		emit(enc(4'h0, 4'd7, 4'd15, 4'd13));
	endfunction

	function automatic void buildProgram(input int test);
		logic [15:0] x;
		logic [15:0] y;
		logic [15:0] z;
		prog.delete();
		// Constants r13=2, r15=1, r12=3
		emit(enc(4'hE, 4'd13, 4'd0, 4'd0));
		emit(enc(4'h5, 4'd15, 4'd13, 4'd1));
		emit(enc(4'h0, 4'd12, 4'd13, 4'd15));
		case (test)
			0: for (int p = 0; p < 5; p++) begin
				x = randWord();
				y = randWord();
				z = randWord();
				if (p == 2) begin
					x = 16'h7FFF;
					y = 16'h0001;
				end else if (p == 3) begin
					x = 16'h8000;
					y = 16'h0001;
				end else if (p == 4) begin
					x = 16'h7F80;
					y = 16'h0181;
				end
				loadWord(4'd1, x);
				loadWord(4'd2, y);
				for (int op = 0; op < 3; op++)
					emit(enc(4'(op), 4'(3 + op), 4'd1, 4'd2));
				emit(enc(4'h7, 4'd6, 4'd1, 4'd2));
				for (int op = 4; op < 7; op++)
					emit(enc(4'(op), 4'(op + 3), 4'd1, z[3:0]));
			end
			1: begin
				x = randWord();
				emit(enc(4'hA, 4'd0, x[7:4], x[3:0]));
				emit(enc(4'hB, 4'd0, x[15:12], x[11:8]));
				emit(enc(4'h0, 4'd3, 4'd0, 4'd15));
				emit(enc(4'h2, 4'd4, 4'd15, 4'd0));
				emit(enc(4'h1, 4'd5, 4'd0, 4'd15));
				// Reserved opcode, no-op
				emit({4'h3, x[11:0]});
				emit(enc(4'h0, 4'd6, 4'd3, 4'd15));
			end
			2: for (int k = 0; k < 3; k++) begin
				x = randWord() & 16'h3FFE;
				y = randWord();
				z = randWord();
				loadWord(4'd1, x);
				loadWord(4'd2, y);
				emit(enc(4'h9, 4'd2, 4'd1, z[3:0]));
				emit(enc(4'h8, 4'd3, 4'd1, z[3:0]));
				emit(enc(4'h8, 4'd4, 4'd1, z[3:0] ^ 4'd1));
			end
			3: begin
				// r6 = 7FFF for the overflow case
				emit(enc(4'h1, 4'd4, 4'd0, 4'd15));
				emit(enc(4'h4, 4'd5, 4'd15, 4'd15));
				emit(enc(4'h2, 4'd6, 4'd5, 4'd4));
				for (int c = 0; c < 8; c++)
					for (int sc = 0; sc < 6; sc++)
						branchCase(sc, 3'(c));
			end
			default: begin
				emit(enc(4'hE, 4'd1, 4'd0, 4'd0));
				emit(enc(4'h4, 4'd2, 4'd15, 4'd6));
				emit(enc(4'h1, 4'd3, 4'd13, 4'd13));
				emit({4'hD, 3'd0, 1'b0, 4'd2, 4'd0});
				emit({4'hD, 3'd1, 1'b0, 4'd2, 4'd0});
				// Skipped filler up to word 32
				while (prog.size() < 32)
					emit(enc(4'h0, 4'd4, 4'd15, 4'd13));
				emit(enc(4'hE, 4'd6, 4'd0, 4'd0));
			end
		endcase
		emit(16'hF000);
	endfunction

endpackage

`default_nettype wire

/* logic/cpuTop.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cpu_defs.svh"

module cpuTop
	import cpuPkg::*;
(
	input logic clk,
	input logic rstN,
	output logic [`WORD_WIDTH-1:0] imemAddr,
	input logic [`WORD_WIDTH-1:0] imemData,
	output logic [`WORD_WIDTH-1:0] pc,
	output logic hlt,
	output logic wbEn,
	output logic [`REG_IDX_WIDTH-1:0] wbIdx,
	output logic [`WORD_WIDTH-1:0] wbData
);

	ctrlT ctrl;
	flagsT aluFlags;
	logic [`WORD_WIDTH-1:0] operandA, operandB, aluResult;
	logic [`WORD_WIDTH-1:0] branchOffset, storeData, readData;
	logic [`WORD_WIDTH-1:0] fetchPc, pcPlus2;
	logic branchTaken;

	regFileIf rf ();

	// ==============================
	// Decode and register file
	// ==============================
	controlUnit u_control (
		.instr(imemData), .pcPlus2(pcPlus2), .aluResult(aluResult),
		.readData(readData), .ctrl(ctrl), .operandA(operandA),
		.operandB(operandB), .branchOffset(branchOffset),
		.storeData(storeData), .rf(rf.ctrlPort)
	);

	registerFile u_regs (.clk(clk), .rstN(rstN), .rf(rf.regPort));

	// Execute and memory
	aluUnit u_alu (
		.aluOp(ctrl.aluOp), .a(operandA), .b(operandB),
		.result(aluResult), .flags(aluFlags)
	);

	dataMemory u_dmem (
		.clk(clk), .rstN(rstN), .ctrl(ctrl), .addr(aluResult),
		.writeData(storeData), .readData(readData)
	);

	// Branch condition sits in instr[11:9]
	branchUnit u_branch (
		.clk(clk), .rstN(rstN), .ctrl(ctrl), .aluFlags(aluFlags),
		.cond(condT'(imemData[11:9])), .branchTaken(branchTaken)
	);

	// BR target is rs passed through the ALU
	fetchUnit u_fetch (
		.clk(clk), .rstN(rstN), .ctrl(ctrl), .branchTaken(branchTaken),
		.branchOffset(branchOffset), .regTarget(aluResult),
		.pc(fetchPc), .pcPlus2(pcPlus2)
	);

	assign imemAddr = fetchPc;
	assign pc = fetchPc;
	assign hlt = ctrl.halt;

	// Writeback trace straight off the write port, quiet in reset
	assign wbEn = rf.wrEn && rstN;
	assign wbIdx = rf.wrIdx;
	assign wbData = rf.wrData;

endmodule

`default_nettype wire

/* logic/dataMemory.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cpu_defs.svh"

module dataMemory
	import cpuPkg::*;
(
	input logic clk,
	input logic rstN,
	input ctrlT ctrl,
	input logic [`WORD_WIDTH-1:0] addr,
	input logic [`WORD_WIDTH-1:0] writeData,
	output logic [`WORD_WIDTH-1:0] readData
);

	localparam int AW = $clog2(`DMEM_DEPTH);

	logic [`WORD_WIDTH-1:0] mem [`DMEM_DEPTH];
	logic [AW-1:0] wordIdx;

	// Byte address to word index
	assign wordIdx = addr[AW:1];

	// Same-cycle read
	assign readData = mem[wordIdx];

	// Store on the edge, reset wipes the whole array
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < `DMEM_DEPTH; i++)
				mem[i] <= '0;
		end else if (ctrl.memWrite) begin
			mem[wordIdx] <= writeData;
		end
	end

endmodule

`default_nettype wire

/* logic/fetchUnit.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cpu_defs.svh"

module fetchUnit
	import cpuPkg::*;
(
	input logic clk,
	input logic rstN,
	input ctrlT ctrl,
	input logic branchTaken,
	input logic [`WORD_WIDTH-1:0] branchOffset,
	input logic [`WORD_WIDTH-1:0] regTarget,
	output logic [`WORD_WIDTH-1:0] pc,
	output logic [`WORD_WIDTH-1:0] pcPlus2
);

	logic [`WORD_WIDTH-1:0] branchTarget;
	logic [`WORD_WIDTH-1:0] nextPc;

	// ==============================
	// Adders
	// ==============================
	assign pcPlus2 = pc + `WORD_WIDTH'd2;
	// B is relative to the following instruction
	assign branchTarget = pcPlus2 + branchOffset;

	// Next PC priority: halt, BR, B, sequential
	always_comb begin
		if (ctrl.halt)
			nextPc = pc;
		else if (branchTaken && ctrl.branchReg)
			nextPc = regTarget;
		else if (branchTaken)
			nextPc = branchTarget;
		else
			nextPc = pcPlus2;
	end

	// PC register
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			pc <= '0;
		else
			pc <= nextPc;
	end

	// Halfword aligned, also catches odd BR targets from the register file
	assert property (@(posedge clk) disable iff (!rstN) pc[0] == 1'b0);

endmodule

`default_nettype wire

/* logic/branchUnit.sv */
`timescale 1ns/1ns
`default_nettype none

module branchUnit
	import cpuPkg::*;
(
	input logic clk,
	input logic rstN,
	input ctrlT ctrl,
	input flagsT aluFlags,
	input condT cond,
	output logic branchTaken
);

	flagsT flagReg;
	logic condMet;

	// ==============================
	// N/V/Z register
	// ==============================
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			flagReg <= '0;
		end else if (ctrl.flagWrite) begin
			// Z on every flag-setting op
			flagReg.z <= aluFlags.z;
			// N and V from add and subtract only
			if ((ctrl.aluOp == aluAdd) || (ctrl.aluOp == aluSub)) begin
				flagReg.n <= aluFlags.n;
				flagReg.v <= aluFlags.v;
			end
		end
	end

	// Condition check against stored flags
	always_comb begin
		case (cond)
			condNe: condMet = !flagReg.z;
			condEq: condMet = flagReg.z;
			condGt: condMet = !flagReg.z && !flagReg.n;
			condLt: condMet = flagReg.n;
			condGe: condMet = flagReg.z || !flagReg.n;
			condLe: condMet = flagReg.n || flagReg.z;
			condOv: condMet = flagReg.v;
			default: condMet = 1'b1;
		endcase
	end

	assign branchTaken = ctrl.isBranch && condMet;

endmodule

`default_nettype wire

/* logic/registerFile.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cpu_defs.svh"

module registerFile (
	input logic clk,
	input logic rstN,
	regFileIf.regPort rf
);

	localparam int W = `WORD_WIDTH;

	logic [W-1:0] regs [`REG_COUNT];

	// ==============================
	// Write port
	// ==============================
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < `REG_COUNT; i++)
				regs[i] <= '0;
		end else if (rf.wrEn && (rf.wrIdx != '0)) begin
			regs[rf.wrIdx] <= rf.wrData;
		end
	end

	// Read ports, r0 reads zero
	assign rf.rdDataA = (rf.rdIdxA == '0) ? '0 : regs[rf.rdIdxA];
	assign rf.rdDataB = (rf.rdIdxB == '0) ? '0 : regs[rf.rdIdxB];

	// Decoder must name a real destination when writing
	assert property (@(posedge clk) disable iff (!rstN) rf.wrEn |-> !$isunknown(rf.wrIdx));

endmodule

`default_nettype wire

/* logic/aluUnit.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cpu_defs.svh"

module aluUnit
	import cpuPkg::*;
(
	input aluOpT aluOp,
	input logic [`WORD_WIDTH-1:0] a,
	input logic [`WORD_WIDTH-1:0] b,
	output logic [`WORD_WIDTH-1:0] result,
	output flagsT flags
);

	localparam int W = `WORD_WIDTH;
	localparam logic [W-1:0] MaxPos = {1'b0, {(W-1){1'b1}}};
	localparam logic [W-1:0] MaxNeg = {1'b1, {(W-1){1'b0}}};

	logic [W-1:0] sum;
	logic [W-1:0] diff;
	logic sumOvf;
	logic diffOvf;
	logic [2*W-1:0] rotWide;
	logic [W-1:0] paddsb;

	// One byte lane, clamps to -128..127
	function automatic logic [7:0] addSatByte(input logic [7:0] x, input logic [7:0] y);
		logic [7:0] s;
		s = x + y;
		if ((x[7] == y[7]) && (s[7] != x[7]))
			return x[7] ? 8'h80 : 8'h7F;
		return s;
	endfunction

	// ==============================
	// Adder and subtractor
	// ==============================
	assign sum = a + b;
	assign diff = a - b;

	// Signed overflow from operand and result signs
	assign sumOvf = (a[W-1] == b[W-1]) && (sum[W-1] != a[W-1]);
	assign diffOvf = (a[W-1] != b[W-1]) && (diff[W-1] != a[W-1]);

	// Rotate via doubled word
	assign rotWide = {a, a} >> b[3:0];

	// Independent byte lanes
	assign paddsb = {addSatByte(a[15:8], b[15:8]), addSatByte(a[7:0], b[7:0])};

	// ==============================
	// Result select
	// ==============================
	always_comb begin
		case (aluOp)
			aluAdd: result = sumOvf ? (a[W-1] ? MaxNeg : MaxPos) : sum;
			aluSub: result = diffOvf ? (a[W-1] ? MaxNeg : MaxPos) : diff;
			aluXor: result = a ^ b;
			aluSll: result = a << b[3:0];
			aluSra: result = $signed(a) >>> b[3:0];
			aluRor: result = rotWide[W-1:0];
			aluPaddsb: result = paddsb;
			default: result = a;
		endcase
	end

	// Flags computed every cycle, the flag register decides what to keep
	assign flags.n = result[W-1];
	assign flags.z = (result == '0);
	assign flags.v = ((aluOp == aluAdd) && sumOvf) || ((aluOp == aluSub) && diffOvf);

	// No X on the result once an operation is selected
	always_comb begin
		if (!$isunknown(aluOp))
			assert final (!$isunknown(result));
	end

endmodule

`default_nettype wire

/* logic/controlUnit.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cpu_defs.svh"

module controlUnit
	import cpuPkg::*;
(
	input logic [`WORD_WIDTH-1:0] instr,
	input logic [`WORD_WIDTH-1:0] pcPlus2,
	input logic [`WORD_WIDTH-1:0] aluResult,
	input logic [`WORD_WIDTH-1:0] readData,
	output ctrlT ctrl,
	output logic [`WORD_WIDTH-1:0] operandA,
	output logic [`WORD_WIDTH-1:0] operandB,
	output logic [`WORD_WIDTH-1:0] branchOffset,
	output logic [`WORD_WIDTH-1:0] storeData,
	regFileIf.ctrlPort rf
);

	localparam int W = `WORD_WIDTH;

	opcodeT opcode;
	logic isPartial;
	logic [W-1:0] memOffset;
	logic [W-1:0] shiftAmt;

	assign opcode = opcodeT'(instr[15:12]);
	assign isPartial = (opcode == opLlb) || (opcode == opLhb);

	// ==============================
	// Immediates
	// ==============================

	// Signed word offset for LW and SW
	assign memOffset = {{(W-5){instr[3]}}, instr[3:0], 1'b0};
	// Unsigned shift count
	assign shiftAmt = {{(W-4){1'b0}}, instr[3:0]};
	// B target offset in halfwords
	assign branchOffset = {{(W-10){instr[8]}}, instr[8:0], 1'b0};

	// ==============================
	// Decode
	// ==============================
	always_comb begin
		ctrl = '0;
		ctrl.aluOp = aluPass;
		case (opcode)
			opAdd: ctrl = '{aluAdd, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};
			opSub: ctrl = '{aluSub, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};
			opXor: ctrl = '{aluXor, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};
			opSll: ctrl = '{aluSll, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};
			opSra: ctrl = '{aluSra, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};
			opRor: ctrl = '{aluRor, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};
			opPaddsb: ctrl = '{aluPaddsb, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
			// Base plus offset through the adder
			opLw: ctrl = '{aluAdd, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
			opSw: ctrl = '{aluAdd, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0};
			opLlb, opLhb, opPcs: ctrl.regWrite = 1'b1;
			opB: ctrl.isBranch = 1'b1;
			// Jump target passes through the ALU
			opBr: ctrl = '{aluPass, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0};
			opHlt: ctrl.halt = 1'b1;
			// RED is reserved, no-op
			default: ctrl.aluOp = aluPass;
		endcase
	end

	// Register selection, LLB and LHB read their own destination
	assign rf.rdIdxA = isPartial ? instr[11:8] : instr[7:4];
	assign rf.rdIdxB = (opcode == opSw) ? instr[11:8] : instr[3:0];
	assign rf.wrIdx = instr[11:8];
	assign rf.wrEn = ctrl.regWrite;

	assign operandA = rf.rdDataA;
	assign storeData = rf.rdDataB;

	// ALU operand B
	always_comb begin
		case (opcode)
			opLw, opSw: operandB = memOffset;
			opSll, opSra, opRor: operandB = shiftAmt;
			default: operandB = rf.rdDataB;
		endcase
	end

	// Writeback select
	always_comb begin
		case (opcode)
			opLlb: rf.wrData = {rf.rdDataA[W-1:8], instr[7:0]};
			opLhb: rf.wrData = {instr[7:0], rf.rdDataA[7:0]};
			opPcs: rf.wrData = pcPlus2;
			opLw: rf.wrData = readData;
			default: rf.wrData = aluResult;
		endcase
	end

	// PC out of reset, fetched word must decode to a known write strobe
	always_comb begin
		if (!$isunknown(pcPlus2))
			assert final (!$isunknown(rf.wrEn));
	end

endmodule

`default_nettype wire

/* logic/regFileIf.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cpu_defs.svh"

interface regFileIf;

	// Two read ports
	logic [`REG_IDX_WIDTH-1:0] rdIdxA;
	logic [`REG_IDX_WIDTH-1:0] rdIdxB;
	logic [`WORD_WIDTH-1:0] rdDataA;
	logic [`WORD_WIDTH-1:0] rdDataB;

	// One write port
	logic [`REG_IDX_WIDTH-1:0] wrIdx;
	logic [`WORD_WIDTH-1:0] wrData;
	logic wrEn;

	// Register file side
	modport regPort (
		input rdIdxA, rdIdxB, wrIdx, wrData, wrEn,
		output rdDataA, rdDataB
	);

	// Decoder side
	modport ctrlPort (
		output rdIdxA, rdIdxB, wrIdx, wrData, wrEn,
		input rdDataA, rdDataB
	);

endinterface

`default_nettype wire

/* logic/cpuPkg.sv */
`default_nettype none

package cpuPkg;

	// Opcode field, instr[15:12]
	typedef enum logic [3:0] {
		opAdd, opSub, opXor, opRed,
		opSll, opSra, opRor, opPaddsb,
		opLw, opSw, opLlb, opLhb,
		opB, opBr, opPcs, opHlt
	} opcodeT;

	// ALU operations, add also serves address arithmetic
	typedef enum logic [2:0] {
		aluAdd, aluSub, aluXor, aluSll, aluSra, aluRor, aluPaddsb, aluPass
	} aluOpT;

	// Branch condition field, instr[11:9]
	typedef enum logic [2:0] {
		condNe, condEq, condGt, condLt, condGe, condLe, condOv, condAlways
	} condT;

	// Flag update rule
	// ADD and SUB write N, V and Z, V is signed overflow with saturation
	// XOR, SLL, SRA, ROR write Z only
	// Everything else leaves the flags alone
	typedef struct packed {
		logic n;
		logic v;
		logic z;
	} flagsT;

	// Decoded control word
	typedef struct packed {
		aluOpT aluOp;
		logic regWrite;
		logic flagWrite;
		logic memWrite;
		logic isBranch;
		logic branchReg;
		logic halt;
	} ctrlT;

endpackage

`default_nettype wire

/* include/cpu_defs.svh */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// ==============================
// Core sizing
// ==============================

// Data and instruction word
`define WORD_WIDTH 16

// Architectural registers, r0 hardwired to zero
`define REG_COUNT 16
`define REG_IDX_WIDTH 4

// Data memory words, byte addressed by the core
`define DMEM_DEPTH 256

`endif
